/* source/ga_defines.svh */
`ifndef GA_DEFINES_SVH
`define GA_DEFINES_SVH

// sequencer cycle length in ck16 periods
`define GA_SLOTS 16

// hsync falling edges between two raster interrupts
`define GA_INT_LINES 52

// border ink loaded at reset, hardware color 11 is white
`define GA_BORDER_RESET 5'd11

// composite sync pulse window, char clocks (horizontal) or lines (vertical)
`define GA_CSYNC_FIRST 2
`define GA_CSYNC_LAST 5

`endif

/* source/ga_pkg.sv */
package ga_pkg;

  typedef logic [4:0] hw_color_t;  // hardware color number, 0..31
  typedef logic [3:0] slot_t;      // sequencer slot

  typedef enum logic [1:0] {
    mode_0,  // 160 wide, 16 inks
    mode_1,  // 320 wide, 4 inks
    mode_2,  // 640 wide, 2 inks
    mode_3   // undocumented, 160 wide with 4 inks
  } video_mode_t;

  // register write opcode, data bits 7:6
  typedef enum logic [1:0] {
    cmd_pen,
    cmd_ink,
    cmd_rmr,
    cmd_unused
  } ga_cmd_t;

  // z80 side of the bus
  typedef struct packed {
    logic a15;
    logic a14;
    logic mreq_n;
    logic iorq_n;
    logic m1_n;
    logic rd_n;
  } cpu_bus_t;

  // 6845 outputs seen by the gate array
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic dispen;
  } crtc_t;

  typedef struct packed {
    logic ras_n;
    logic cas_n;
    logic casad_n;
    logic mwe_n;
  } dram_ctl_t;

  // each channel is a level plus its output enable
  typedef struct packed {
    logic red;
    logic red_oe;
    logic green;
    logic green_oe;
    logic blue;
    logic blue_oe;
  } rgb_pin_t;

endpackage

/* source/ga_sequencer.sv */
`timescale 1ns/10ps
`include "ga_defines.svh"

module ga_sequencer (
  input  logic              ck16,
  input  logic              reset_interrupt,
  input  ga_pkg::cpu_bus_t  cpu,
  input  logic              ramrd_n,   // cpu reads ram this cycle
  output ga_pkg::slot_t     slot,
  output logic              phi_n,
  output logic              ready,
  output logic              cpu_n,
  output logic              cclk,
  output logic              en244_n,
  output ga_pkg::dram_ctl_t dram
);
  import ga_pkg::*;

  slot_t slot_q;
  logic  ras_q;
  logic  cas_q;
  logic  mwe_int;   // sequencer write window, not yet qualified
  logic  memwrite;

  assign memwrite = ~cpu.mreq_n & cpu.rd_n & cpu.m1_n;  // real memory write only

  //////////////////////////////////////////////////////////////////////
  // slot counter, free running

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      slot_q <= '0;
    end else if (slot_q == slot_t'(`GA_SLOTS - 1)) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_q + 4'd1;
    end
  end

  assign slot  = slot_q;
  assign phi_n = slot_q[1];  // cpu clock is ck16/4

  //////////////////////////////////////////////////////////////////////
  // strobes, each one registered off the slot before it

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      ras_q   <= 1'b1;
      cas_q   <= 1'b1;
      cpu_n   <= 1'b1;
      ready   <= 1'b0;
      cclk    <= 1'b0;
      mwe_int <= 1'b1;
      en244_n <= 1'b1;
    end else begin
      // bus buffer open for i/o in slots 4..10
      if (slot_q >= 4'd4 && slot_q <= 4'd10 && !cpu.iorq_n) begin
        en244_n <= 1'b0;
      end else if (slot_q == 4'd11) begin
        en244_n <= 1'b1;
      end
      case (slot_q)
        4'd2: begin
          ras_q <= 1'b1;
          cpu_n <= 1'b0;  // cpu owns the dram
        end
        4'd3: begin
          cclk  <= 1'b0;
          cas_q <= 1'b1;
        end
        4'd4: begin
          ras_q <= 1'b0;
          ready <= 1'b1;
        end
        4'd5: begin
          if (!ramrd_n || memwrite) begin
            cas_q <= 1'b0;  // second cas only for a cpu access
          end
        end
        4'd6: mwe_int <= 1'b0;
        4'd8: begin
          ras_q <= 1'b1;
          ready <= 1'b0;
          cpu_n <= 1'b1;  // back to video fetch
        end
        4'd9: begin
          mwe_int <= 1'b1;
          cas_q   <= 1'b1;
        end
        4'd10: ras_q <= 1'b0;
        4'd11, 4'd15: cas_q <= 1'b0;  // video byte fetches
        4'd14: begin
          cclk  <= 1'b1;
          cas_q <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign dram = '{ras_n: ras_q, cas_n: cas_q, casad_n: ras_q,
                  mwe_n: mwe_int | ~memwrite};

  // wait window lies inside the cpu phase
  a_ready_in_cpu_phase: assert property (@(posedge ck16) disable iff (reset_interrupt)
    ready |-> !cpu_n);

endmodule

/* source/ga_registers.sv */
`timescale 1ns/10ps
`include "ga_defines.svh"

module ga_registers (
  input  logic                ck16,
  input  logic                reset_interrupt,
  input  ga_pkg::cpu_bus_t    cpu,
  input  logic [7:0]          d,
  input  logic                en244_n,
  input  logic                hsync,
  input  logic [3:0]          pal_index,
  input  logic                border_time,
  output ga_pkg::video_mode_t video_mode,
  output ga_pkg::hw_color_t   color,
  output logic                romen_n,
  output logic                ramrd_n,
  output logic                int_clear
);
  import ga_pkg::*;

  hw_color_t   pen_q;          // bit 4 selects the border
  hw_color_t   ink_q [16];
  hw_color_t   border_q;
  logic        upper_rom_off;  // c000-ffff
  logic        lower_rom_off;  // 0000-3fff
  video_mode_t mode_pending;   // applied at the next hsync
  ga_cmd_t     cmd;
  logic        wr_en;
  logic        memread;

  assign cmd     = ga_cmd_t'(d[7:6]);
  assign memread = ~cpu.mreq_n & ~cpu.rd_n;

  // i/o write to 01xx xxxx xxxx xxxx while the buffer is open
  assign wr_en = ~cpu.a15 & cpu.a14 & ~cpu.iorq_n & cpu.rd_n & cpu.m1_n & ~en244_n;

  assign int_clear = wr_en && cmd == cmd_rmr && d[4];  // rmr bit 4 is a strobe

  //////////////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      pen_q         <= '0;
      border_q      <= `GA_BORDER_RESET;
      upper_rom_off <= 1'b0;
      lower_rom_off <= 1'b0;
      mode_pending  <= mode_0;
      video_mode    <= mode_0;
      for (int i = 0; i < 16; i++) begin
        ink_q[i] <= '0;
      end
    end else begin
      if (wr_en) begin
        case (cmd)
          cmd_pen: pen_q <= d[4:0];
          cmd_ink: begin
            if (pen_q[4]) begin
              border_q <= d[4:0];
            end else begin
              ink_q[pen_q[3:0]] <= d[4:0];
            end
          end
          cmd_rmr: begin
            upper_rom_off <= d[3];
            lower_rom_off <= d[2];
            mode_pending  <= video_mode_t'(d[1:0]);
          end
          default: ;  // opcode 3 is for ram banking, not here
        endcase
      end
      if (hsync) begin
        video_mode <= mode_pending;  // mode only switches in retrace
      end
    end
  end

  assign color = border_time ? border_q : ink_q[pal_index];

  //////////////////////////////////////////////////////////////////////
  // rom and ram read enables

  always_comb begin
    romen_n = 1'b1;
    if (memread && !cpu.a15 && !cpu.a14 && !lower_rom_off) begin
      romen_n = 1'b0;
    end
    if (memread && cpu.a15 && cpu.a14 && !upper_rom_off) begin
      romen_n = 1'b0;
    end
  end

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      ramrd_n <= 1'b1;
    end else begin
      ramrd_n <= ~(memread & romen_n);  // any read the roms do not answer
    end
  end

  a_mode_at_hsync: assert property (@(posedge ck16) disable iff (reset_interrupt)
    !$stable(video_mode) && !$past(reset_interrupt) |-> $past(hsync));

endmodule

/* source/ga_interrupt.sv */
`timescale 1ns/10ps
`include "ga_defines.svh"

module ga_interrupt (
  input  logic             ck16,
  input  logic             reset_interrupt,
  input  ga_pkg::crtc_t    crtc,
  input  ga_pkg::cpu_bus_t cpu,
  input  logic             int_clear,
  output logic             int_n
);

  localparam logic [5:0] last_line = 6'(`GA_INT_LINES - 1);

  logic       hsync_prev;
  logic       vsync_prev;
  logic       intack_prev;
  logic [1:0] vs_lines;   // hsyncs since vsync start, stops at 2
  logic [5:0] line_cnt;
  logic       intack;
  logic       hs_fall;
  logic       ack_end;

  assign intack  = ~cpu.iorq_n & ~cpu.m1_n;   // z80 interrupt acknowledge
  assign hs_fall = hsync_prev & ~crtc.hsync;
  assign ack_end = intack_prev & ~intack & ~int_n;

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      hsync_prev  <= 1'b0;
      vsync_prev  <= 1'b0;
      intack_prev <= 1'b0;
      vs_lines    <= '0;
      line_cnt    <= '0;
      int_n       <= 1'b1;
    end else begin
      hsync_prev  <= crtc.hsync;
      vsync_prev  <= crtc.vsync;
      intack_prev <= intack;
      if (!vsync_prev && crtc.vsync) begin
        vs_lines <= '0;
      end
      if (hs_fall) begin
        line_cnt <= line_cnt + 6'd1;
        if (!crtc.vsync) begin
          if (line_cnt == last_line) begin
            line_cnt <= '0;
            int_n    <= 1'b0;  // regular raster interrupt
          end
        end else begin
          if (vs_lines != 2'd2) begin
            vs_lines <= vs_lines + 2'd1;
          end
          if (vs_lines == 2'd1) begin  // second line of vsync
            line_cnt <= '0;
            if (!line_cnt[5] || line_cnt == last_line) begin
              int_n <= 1'b0;
            end
          end
        end
      end
      // ack end or rmr clear wins over a new interrupt
      if (ack_end || int_clear) begin
        int_n <= 1'b1;
        if (int_clear) begin
          line_cnt <= '0;
        end else begin
          line_cnt[5] <= 1'b0;  // keeps the next one at least 32 lines away
        end
      end
    end
  end

  a_no_int_on_clear: assert property (@(posedge ck16) disable iff (reset_interrupt)
    int_clear |=> !$fell(int_n));

endmodule

/* source/ga_pixel_shifter.sv */
`timescale 1ns/10ps

module ga_pixel_shifter (
  input  logic                ck16,
  input  logic                reset_interrupt,
  input  ga_pkg::slot_t       slot,
  input  logic [7:0]          d,
  input  ga_pkg::video_mode_t video_mode,
  input  ga_pkg::crtc_t       crtc,
  output logic [3:0]          pal_index,
  output logic                border_time
);
  import ga_pkg::*;

  logic [7:0] byte_q;    // last byte latched off the dram bus
  logic [7:0] shift_q;
  logic       shift_now;

  // slots 7/15 for every mode, plus 1/5/9/13 outside mode 0, plus all of mode 2
  assign shift_now = (slot[2:0] == 3'd7)
                  || (video_mode != mode_0 && slot[1:0] == 2'd1)
                  || (video_mode == mode_2);

  always_ff @(posedge ck16) begin
    if (slot == 4'd3 || slot == 4'd11) begin
      shift_q <= byte_q;
    end else if (shift_now) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
    if (slot == 4'd3 || slot == 4'd15) begin
      byte_q <= d;  // two fetches per slot cycle
    end
  end

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      border_time <= 1'b0;
    end else if (slot == 4'd3) begin
      border_time <= ~crtc.dispen;
    end
  end

  // pixel bits are interleaved across the byte
  always_comb begin
    case (video_mode)
      mode_0:  pal_index = {shift_q[1], shift_q[5], shift_q[3], shift_q[7]};
      mode_2:  pal_index = {3'b000, shift_q[7]};
      default: pal_index = {2'b00, shift_q[3], shift_q[7]};  // modes 1 and 3
    endcase
  end

endmodule

/* source/ga_color_dac.sv */
`timescale 1ns/10ps

module ga_color_dac (
  input  ga_pkg::hw_color_t color,
  input  logic              hsync,
  input  logic              vsync,
  output ga_pkg::rgb_pin_t  rgb
);

  // {level, output enable} per channel
  localparam logic [1:0] lo  = 2'b01;  // driven low
  localparam logic [1:0] mid = 2'b00;  // released, the resistor net sets half level
  localparam logic [1:0] hi  = 2'b11;  // driven high

  always_comb begin
    if (hsync || vsync) begin
      rgb = {lo, lo, lo};  // black during blanking
    end else begin
      case (color)  // red, green, blue
        5'd00, 5'd01: rgb = {mid, mid, mid};
        5'd02: rgb = {lo,  hi,  mid};
        5'd03: rgb = {hi,  hi,  mid};
        5'd04: rgb = {lo,  lo,  mid};
        5'd05: rgb = {hi,  lo,  mid};
        5'd06: rgb = {lo,  mid, mid};
        5'd07: rgb = {hi,  mid, mid};
        5'd08: rgb = {hi,  lo,  mid};
        5'd09: rgb = {hi,  hi,  mid};
        5'd10: rgb = {hi,  hi,  lo};
        5'd11: rgb = {hi,  hi,  hi};   // white
        5'd12: rgb = {hi,  lo,  lo};
        5'd13: rgb = {hi,  lo,  hi};
        5'd14: rgb = {hi,  mid, lo};
        5'd15: rgb = {hi,  mid, hi};
        5'd16: rgb = {lo,  lo,  mid};
        5'd17: rgb = {lo,  hi,  mid};
        5'd18: rgb = {lo,  hi,  lo};
        5'd19: rgb = {lo,  hi,  hi};
        5'd20: rgb = {lo,  lo,  lo};   // black
        5'd21: rgb = {lo,  lo,  hi};
        5'd22: rgb = {lo,  mid, lo};
        5'd23: rgb = {lo,  mid, hi};
        5'd24: rgb = {mid, lo,  mid};
        5'd25: rgb = {mid, hi,  mid};
        5'd26: rgb = {mid, hi,  lo};
        5'd27: rgb = {mid, hi,  hi};
        5'd28: rgb = {mid, lo,  lo};
        5'd29: rgb = {mid, lo,  hi};
        5'd30: rgb = {mid, mid, lo};
        default: rgb = {mid, mid, hi};  // 31
      endcase
    end
  end

endmodule

/* source/ga_csync.sv */
`timescale 1ns/10ps
`include "ga_defines.svh"

module ga_csync (
  input  logic          ck16,
  input  logic          reset_interrupt,
  input  ga_pkg::slot_t slot,
  input  ga_pkg::crtc_t crtc,
  output logic          sync_n,
  output logic          hsync_pal,
  output logic          vsync_pal
);

  logic       hsync_prev;
  logic       vsync_prev;
  logic [3:0] cclk_cnt;   // char clocks into hsync
  logic [3:0] line_cnt;   // lines into vsync
  logic       h_sync_n;
  logic       v_sync;

  always_ff @(posedge ck16) begin
    if (reset_interrupt) begin
      hsync_prev <= 1'b0;
      vsync_prev <= 1'b0;
      cclk_cnt   <= '0;
      line_cnt   <= '0;
    end else begin
      hsync_prev <= crtc.hsync;
      vsync_prev <= crtc.vsync;
      if (!hsync_prev && crtc.hsync) begin
        cclk_cnt <= '0;
      end else if (crtc.hsync && slot == 4'd3) begin
        cclk_cnt <= cclk_cnt + 4'd1;  // cclk falls right after slot 3
      end
      if (!vsync_prev && crtc.vsync) begin
        line_cnt <= '0;
      end else if (crtc.vsync && hsync_prev && !crtc.hsync) begin
        line_cnt <= line_cnt + 4'd1;
      end
    end
  end

  assign h_sync_n = ~(crtc.hsync && cclk_cnt >= 4'(`GA_CSYNC_FIRST)
                      && cclk_cnt <= 4'(`GA_CSYNC_LAST));
  assign v_sync   = crtc.vsync && line_cnt >= 4'(`GA_CSYNC_FIRST)
                    && line_cnt <= 4'(`GA_CSYNC_LAST);

  assign sync_n    = h_sync_n ^ v_sync;  // hsync inverted inside the vertical pulse
  assign hsync_pal = h_sync_n;
  assign vsync_pal = ~v_sync;

endmodule

/* source/ga_top.sv */
`timescale 1ns/10ps

module ga_top (
  input  logic              ck16,
  input  logic              reset_interrupt,
  input  ga_pkg::cpu_bus_t  cpu,
  input  logic [7:0]        d,
  input  ga_pkg::crtc_t     crtc,
  output logic              phi_n,
  output logic              ready,
  output logic              int_n,
  output logic              cclk,
  output logic              en244_n,
  output logic              cpu_n,
  output logic              romen_n,
  output logic              ramrd_n,
  output ga_pkg::dram_ctl_t dram,
  output logic              sync_n,
  output logic              hsync_pal,
  output logic              vsync_pal,
  output ga_pkg::rgb_pin_t  rgb
);
  import ga_pkg::*;

  slot_t       slot;
  video_mode_t video_mode;
  hw_color_t   color;        // palette output
  logic [3:0]  pal_index;
  logic        border_time;
  logic        int_clear;

  //////////////////////////////////////////////////////////////////////
  // bus side

  ga_sequencer i_sequencer (
    .ck16, .reset_interrupt, .cpu, .ramrd_n,
    .slot, .phi_n, .ready, .cpu_n, .cclk, .en244_n, .dram
  );

  ga_registers i_registers (
    .ck16, .reset_interrupt, .cpu, .d, .en244_n,
    .hsync(crtc.hsync), .pal_index, .border_time,
    .video_mode, .color, .romen_n, .ramrd_n, .int_clear
  );

  ga_interrupt i_interrupt (
    .ck16, .reset_interrupt, .crtc, .cpu, .int_clear, .int_n
  );

  //////////////////////////////////////////////////////////////////////
  // video side

  ga_pixel_shifter i_pixel_shifter (
    .ck16, .reset_interrupt, .slot, .d, .video_mode, .crtc,
    .pal_index, .border_time
  );

  ga_color_dac i_color_dac (
    .color, .hsync(crtc.hsync), .vsync(crtc.vsync), .rgb
  );

  ga_csync i_csync (
    .ck16, .reset_interrupt, .slot, .crtc, .sync_n, .hsync_pal, .vsync_pal
  );

endmodule

/* test/tb_ga.sv */
`timescale 1ns/10ps

module tb_ga;
  import ga_pkg::*;

  // cycle budget of each test
  localparam int len_seq = 100;
  localparam int len_rom = 400;
  localparam int len_border = 1300;
  localparam int len_pixel = 1500;
  localparam int len_int = 600;
  localparam int len_sync = 200;
  localparam int budget = len_seq + len_rom + len_border + len_pixel + len_int + len_sync + 2000;

  logic      ck16;
  logic      reset_interrupt;
  cpu_bus_t  cpu;
  logic [7:0] d;
  crtc_t     crtc;
  logic      phi_n, ready, int_n, cclk, en244_n, cpu_n, romen_n, ramrd_n;
  logic      sync_n, hsync_pal, vsync_pal;
  dram_ctl_t dram;
  rgb_pin_t  rgb;

  // reference model state
  logic [31:0] seed;
  slot_t       slot_m;
  hw_color_t   ink_m [16];
  hw_color_t   border_m;
  hw_color_t   pen_m;
  logic        up_off_m, lo_off_m;
  video_mode_t pend_m, mode_m;
  logic [7:0]  byte_m, shift_m;
  logic        ramrd_m;
  logic        hs_prev_m, vs_prev_m;
  int          cc_m, ln_m;   // char clocks into hsync and lines into vsync
  int          checks, errors, test_errs;

  ga_top i_dut (.*);

  initial begin
    ck16 = 1'b0;
    forever #4 ck16 = ~ck16;
  end

  initial begin
    #(budget * 8);  // watchdog limit in ns
    $display("watchdog expired, the tests did not complete in time");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [7:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:23];  // upper bits are the better ones
  endfunction

  // 2 bit {level, oe} for one channel letter
  function automatic logic [1:0] level_pins(byte ch);
    if (ch == "H") return 2'b11;
    if (ch == "L") return 2'b01;
    return 2'b00;  // mid level with the pin released
  endfunction

  // hardware palette as red green blue letters
  function automatic rgb_pin_t rgb_of(hw_color_t c);
    string s;
    case (c)
      0, 1: s = "MMM";
      2: s = "LHM";
      3: s = "HHM";
      4: s = "LLM";
      5: s = "HLM";
      6: s = "LMM";
      7: s = "HMM";
      8: s = "HLM";
      9: s = "HHM";
      10: s = "HHL";
      11: s = "HHH";   // white
      12: s = "HLL";
      13: s = "HLH";
      14: s = "HML";
      15: s = "HMH";
      16: s = "LLM";
      17: s = "LHM";
      18: s = "LHL";
      19: s = "LHH";
      20: s = "LLL";   // black
      21: s = "LLH";
      22: s = "LML";
      23: s = "LMH";
      24: s = "MLM";
      25: s = "MHM";
      26: s = "MHL";
      27: s = "MHH";
      28: s = "MLL";
      29: s = "MLH";
      30: s = "MML";
      default: s = "MMH";
    endcase
    return {level_pins(s.getc(0)), level_pins(s.getc(1)), level_pins(s.getc(2))};
  endfunction

  function automatic logic shifts_at(slot_t s, video_mode_t m);
    if (m == mode_2) return 1'b1;
    if (m == mode_0) return s == 7 || s == 15;
    return s == 1 || s == 5 || s == 7 || s == 9 || s == 13 || s == 15;
  endfunction

  function automatic logic [3:0] index_of(logic [7:0] s, video_mode_t m);
    if (m == mode_0) return {s[1], s[5], s[3], s[7]};
    if (m == mode_2) return {3'b000, s[7]};
    return {2'b00, s[3], s[7]};
  endfunction

  function automatic logic romen_exp(cpu_bus_t b, logic up_off, logic lo_off);
    logic rd;
    rd = !b.mreq_n && !b.rd_n;
    return !(rd && ((!b.a15 && !b.a14 && !lo_off) || (b.a15 && b.a14 && !up_off)));
  endfunction

  ////////////////////////////////////////////////////////////////////
  // result checks

  task automatic expect_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("Fail t=%0t %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic dram_is(dram_ctl_t got, dram_ctl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("Fail t=%0t dram expected %b got %b", $time, exp, got);
    end
  endtask

  task automatic rgb_is(rgb_pin_t got, rgb_pin_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("Fail t=%0t rgb expected %b got %b", $time, exp, got);
    end
  endtask

  task automatic end_test(string name);
    $display("test %s finished with %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // one ck16 cycle with the model updated from the pre-edge inputs

  task automatic step();
    @(posedge ck16);
    if (reset_interrupt) begin
      slot_m = 0;
      ramrd_m = 1'b1;
      pen_m = 0;
      border_m = 5'd11;
      up_off_m = 1'b0;
      lo_off_m = 1'b0;
      pend_m = mode_0;
      mode_m = mode_0;
      for (int i = 0; i < 16; i++) ink_m[i] = 0;
      hs_prev_m = 1'b0;
      vs_prev_m = 1'b0;
      cc_m = 0;
      ln_m = 0;
    end else begin
      ramrd_m = !(!cpu.mreq_n && !cpu.rd_n && romen_exp(cpu, up_off_m, lo_off_m));
      if (slot_m == 3 || slot_m == 11) shift_m = byte_m;
      else if (shifts_at(slot_m, mode_m)) shift_m = shift_m << 1;
      if (slot_m == 3 || slot_m == 15) byte_m = d;
      if (crtc.hsync) mode_m = pend_m;  // pending mode lands in retrace
      if (!hs_prev_m && crtc.hsync) cc_m = 0;
      else if (crtc.hsync && slot_m == 3) cc_m++;
      if (!vs_prev_m && crtc.vsync) ln_m = 0;
      else if (crtc.vsync && hs_prev_m && !crtc.hsync) ln_m++;
      hs_prev_m = crtc.hsync;
      vs_prev_m = crtc.vsync;
      slot_m = slot_m + 4'd1;
    end
    @(negedge ck16);
  endtask

  task automatic drive_idle();
    cpu = '{a15: 1'b0, a14: 1'b0, mreq_n: 1'b1, iorq_n: 1'b1, m1_n: 1'b1, rd_n: 1'b1};
  endtask

  // one i/o write held over a whole slot cycle so the en244 window sees it
  task automatic io_write(logic [7:0] v);
    while (slot_m != 0) step();
    cpu = '{a15: 1'b0, a14: 1'b1, mreq_n: 1'b1, iorq_n: 1'b0, m1_n: 1'b1, rd_n: 1'b1};
    d = v;
    repeat (16) step();
    drive_idle();
    case (v[7:6])
      2'd0: pen_m = v[4:0];
      2'd1: begin
        if (pen_m[4]) border_m = v[4:0];
        else ink_m[pen_m[3:0]] = v[4:0];
      end
      2'd2: begin
        up_off_m = v[3];
        lo_off_m = v[2];
        pend_m = video_mode_t'(v[1:0]);
      end
      default: ;
    endcase
  endtask

  task automatic hsync_line();
    crtc.hsync = 1'b1;
    repeat (2) step();
    crtc.hsync = 1'b0;
    repeat (2) step();
  endtask

  task automatic sync_matches();
    logic h_n;
    logic v;
    h_n = !(crtc.hsync && cc_m >= 2 && cc_m <= 5);
    v = crtc.vsync && ln_m >= 2 && ln_m <= 5;
    expect_bit("sync_n", sync_n, h_n ^ v);
    expect_bit("hsync_pal", hsync_pal, h_n);
    expect_bit("vsync_pal", vsync_pal, !v);
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests

  initial begin
    logic [3:0] s;
    logic [7:0] pattern;
    logic [7:0] r;
    logic       mw;
    seed = 32'd52;
    checks = 0;
    errors = 0;
    test_errs = 0;
    byte_m = 0;
    shift_m = 0;
    reset_interrupt = 1'b1;
    drive_idle();
    d = 8'h00;
    crtc = '{vsync: 1'b0, hsync: 1'b0, dispen: 1'b0};
    repeat (3) step();

    // reset levels and then the slot table
    expect_bit("ready", ready, 1'b0);
    expect_bit("cclk", cclk, 1'b0);
    expect_bit("cpu_n", cpu_n, 1'b1);
    expect_bit("en244_n", en244_n, 1'b1);
    expect_bit("ramrd_n", ramrd_n, 1'b1);
    expect_bit("int_n", int_n, 1'b1);
    expect_bit("phi_n", phi_n, 1'b0);
    dram_is(dram, '{ras_n: 1'b1, cas_n: 1'b1, casad_n: 1'b1, mwe_n: 1'b1});
    reset_interrupt = 1'b0;
    repeat (16) step();
    repeat (64) begin
      d = lcg_next();
      step();
      s = slot_m;
      expect_bit("phi_n", phi_n, s[1]);
      expect_bit("ready", ready, s >= 5 && s <= 8);
      expect_bit("cpu_n", cpu_n, !(s >= 3 && s <= 8));
      expect_bit("cclk", cclk, !(s >= 4 && s <= 14));
      expect_bit("en244_n", en244_n, 1'b1);
      // idle bus gives only the two video cas strobes
      dram_is(dram, '{ras_n: (s == 3 || s == 4 || s == 9 || s == 10),
                      cas_n: !(s <= 3 || (s >= 12 && s <= 14)),
                      casad_n: (s == 3 || s == 4 || s == 9 || s == 10),
                      mwe_n: 1'b1});
    end
    end_test("sequencer");

    // rom and ram enables under random rmr rom bits
    repeat (6) begin
      io_write(8'h80 | (lcg_next() & 8'h0f));
      repeat (24) begin
        r = lcg_next();
        cpu = '{a15: r[7], a14: r[6], mreq_n: r[5],
                iorq_n: 1'b1, m1_n: 1'b1, rd_n: r[4]};
        #1;
        expect_bit("romen_n", romen_n, romen_exp(cpu, up_off_m, lo_off_m));
        step();
        expect_bit("ramrd_n", ramrd_n, ramrd_m);
        mw = !cpu.mreq_n && cpu.rd_n;
        expect_bit("mwe_n", dram.mwe_n, !(mw && slot_m >= 7 && slot_m <= 9));
      end
      drive_idle();
    end
    end_test("rom_ram");

    // border color with the display off and black in blanking
    repeat (8) begin
      io_write(lcg_next() & 8'h0f);           // random pen
      io_write(8'h40 | (lcg_next() & 8'h1f));  // its ink
      io_write(8'h10);                         // border pen
      io_write(8'h40 | (lcg_next() & 8'h1f));
      crtc.dispen = 1'b0;
      repeat (16) step();
      repeat (8) begin
        step();
        rgb_is(rgb, rgb_of(border_m));
      end
      crtc.hsync = 1'b1;
      repeat (2) begin
        step();
        rgb_is(rgb, 6'b010101);
      end
      crtc.hsync = 1'b0;
      crtc.vsync = 1'b1;
      repeat (2) begin
        step();
        rgb_is(rgb, 6'b010101);
      end
      crtc.vsync = 1'b0;
    end
    end_test("border");

    // pixel stream per mode
    for (int p = 0; p < 16; p++) begin
      io_write(p[7:0]);
      io_write(8'h40 | (lcg_next() & 8'h1f));
    end
    for (int m = 0; m < 4; m++) begin
      io_write(8'h80 | m[7:0]);
      crtc.hsync = 1'b1;
      step();
      crtc.hsync = 1'b0;
      step();
      pattern = lcg_next();
      d = pattern;
      crtc.dispen = 1'b1;
      repeat (24) step();
      repeat (32) begin
        step();
        rgb_is(rgb, rgb_of(ink_m[index_of(shift_m, mode_m)]));
      end
    end
    crtc.dispen = 1'b0;
    end_test("pixels");

    // raster interrupt with ack and rmr clear
    io_write(8'h90);
    expect_bit("int_n", int_n, 1'b1);
    for (int round = 0; round < 2; round++) begin
      repeat (51) begin
        hsync_line();
        expect_bit("int_n", int_n, 1'b1);
      end
      hsync_line();
      expect_bit("int_n", int_n, 1'b0);
      if (round == 0) begin
        cpu = '{a15: 1'b0, a14: 1'b0, mreq_n: 1'b1, iorq_n: 1'b0, m1_n: 1'b0, rd_n: 1'b1};
        repeat (2) step();
        expect_bit("int_n", int_n, 1'b0);
        drive_idle();
        step();
        expect_bit("int_n", int_n, 1'b1);
      end else begin
        io_write(8'h90);
        expect_bit("int_n", int_n, 1'b1);
      end
    end
    end_test("interrupt");

    // composite sync windows
    crtc.hsync = 1'b1;
    repeat (100) begin
      step();
      sync_matches();
    end
    crtc.hsync = 1'b0;
    repeat (8) begin
      step();
      sync_matches();
    end
    crtc.vsync = 1'b1;
    repeat (8) begin
      crtc.hsync = 1'b1;
      repeat (3) begin
        step();
        sync_matches();
      end
      crtc.hsync = 1'b0;
      repeat (5) begin
        step();
        sync_matches();
      end
    end
    crtc.vsync = 1'b0;
    repeat (4) begin
      step();
      sync_matches();
    end
    end_test("csync");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* ga_gate_array.f */
+incdir+source
source/ga_pkg.sv
source/ga_sequencer.sv
source/ga_registers.sv
source/ga_interrupt.sv
source/ga_pixel_shifter.sv
source/ga_color_dac.sv
source/ga_csync.sv
source/ga_top.sv
test/tb_ga.sv
